//--- verilog/mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;
    localparam logic [31:0] PC_STEP  = 32'd4;
    localparam logic [4:0]  LINK_REG = 5'd31;

    // the same word read as register or immediate format
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } inst_u;

    typedef enum logic [7:0] {
        // alu
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLT, OP_SLL, OP_SRL, OP_SRA,
        OP_LU,
        // branch and jump
        OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
        OP_BLTZ, OP_BGEZ, OP_BLTZAL, OP_BGEZAL,
        OP_J, OP_JAL, OP_JR, OP_JALR,
        // memory
        OP_LB, OP_LH, OP_LW, OP_LWL, OP_LWR,
        OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR,
        OP_CACHE,
        // system
        OP_MFC0, OP_MTC0, OP_ERET, OP_WAIT,
        OP_TLBWI, OP_SYSCALL, OP_BREAK,
        OP_INVALID = 8'hff
    } op_e;

    typedef struct packed {
        op_e         op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
        logic        flag_unsigned;
    } i_dec_t;

    typedef struct packed {
        op_e        op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic       flag_unsigned;
    } r_dec_t;

    // one record per instruction, handed downstream
    typedef struct packed {
        op_e         op;
        logic [4:0]  src_a;
        logic [4:0]  src_b;
        logic [4:0]  dest;          // 0 when nothing written
        logic [31:0] imm32;
        logic        uses_imm;
        logic        flag_unsigned;
        logic [31:0] pc;
    } dec_t;

endpackage

`default_nettype wire

//--- verilog/if_wb.sv
`timescale 1ns/1ps
`default_nettype none

module if_wb (
    input  wire              clk,
    input  wire              arst_n,
    output logic [31:0]      wb_adr,
    output logic             wb_cyc,
    output logic             wb_stb,
    input  wire  [31:0]      wb_dat,
    input  wire              wb_ack,
    input  wire              advance,
    output mips_pkg::inst_u  inst,
    output logic [31:0]      pc,
    output logic             fetch_valid
);

    logic [31:0] fetch_adr;     // address of the read in flight or next
    logic        cyc_q;
    logic        full_q;
    logic        take;
    logic        room;

    // word lands in the register this edge
    assign take = cyc_q && wb_ack;

    // register empty, or being drained by merge
    assign room = !full_q || advance;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cyc_q     <= 1'b0;
            full_q    <= 1'b0;
            fetch_adr <= mips_pkg::RESET_PC;
        end else begin
            if (cyc_q)
                cyc_q <= !wb_ack;       // end of cycle on ack
            else
                cyc_q <= room;

            full_q <= take || (full_q && !advance);

            if (take)
                fetch_adr <= fetch_adr + mips_pkg::PC_STEP;
        end
    end

    // fetched word and its pc
    always_ff @(posedge clk) begin
        if (take) begin
            inst <= wb_dat;
            pc   <= fetch_adr;
        end
    end

    // read only classic master, stb follows cyc
    assign wb_cyc = cyc_q;
    assign wb_stb = cyc_q;
    assign wb_adr = fetch_adr;

    assign fetch_valid = full_q;

endmodule

`default_nettype wire

//--- verilog/id_i.sv
`timescale 1ns/1ps
`default_nettype none

module id_i (
    input  wire mips_pkg::inst_u inst,
    output mips_pkg::i_dec_t     i_dec
);

    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [5:0] funct;
    logic       flag_u;
    mips_pkg::op_e op;

    assign opcode = inst.i.opcode;
    assign rs     = inst.i.rs;
    assign rt     = inst.i.rt;
    assign funct  = inst.i.imm[5:0];    // cop0 function

    // addiu, sltiu, lbu, lhu
    assign flag_u = (opcode == 6'h09) || (opcode == 6'h0b) ||
                    (opcode == 6'h24) || (opcode == 6'h25);

    always_comb begin
        op = mips_pkg::OP_INVALID;
        case (opcode)
            6'h01: begin                // regimm, by rt
                case (rt)
                    5'h00: op = mips_pkg::OP_BLTZ;
                    5'h01: op = mips_pkg::OP_BGEZ;
                    5'h10: op = mips_pkg::OP_BLTZAL;
                    5'h11: op = mips_pkg::OP_BGEZAL;
                    default: op = mips_pkg::OP_INVALID;
                endcase
            end
            6'h02: op = mips_pkg::OP_J;
            6'h03: op = mips_pkg::OP_JAL;
            6'h04: op = mips_pkg::OP_BEQ;
            6'h05: op = mips_pkg::OP_BNE;
            6'h06: op = mips_pkg::OP_BLEZ;
            6'h07: op = mips_pkg::OP_BGTZ;
            6'h08, 6'h09: op = mips_pkg::OP_ADD;
            6'h0a, 6'h0b: op = mips_pkg::OP_SLT;
            6'h0c: op = mips_pkg::OP_AND;
            6'h0d: op = mips_pkg::OP_OR;
            6'h0e: op = mips_pkg::OP_XOR;
            6'h0f: op = mips_pkg::OP_LU;
            6'h10: begin                // cop0
                if (rs == 5'h00)
                    op = mips_pkg::OP_MFC0;
                else if (rs == 5'h04)
                    op = mips_pkg::OP_MTC0;
                else if (rs[4]) begin
                    case (funct)
                        6'h18: op = mips_pkg::OP_ERET;
                        6'h20: op = mips_pkg::OP_WAIT;
                        6'h02: op = mips_pkg::OP_TLBWI;
                        default: op = mips_pkg::OP_INVALID;
                    endcase
                end
            end
            6'h20, 6'h24: op = mips_pkg::OP_LB;
            6'h21, 6'h25: op = mips_pkg::OP_LH;
            6'h22: op = mips_pkg::OP_LWL;
            6'h23: op = mips_pkg::OP_LW;
            6'h26: op = mips_pkg::OP_LWR;
            6'h28: op = mips_pkg::OP_SB;
            6'h29: op = mips_pkg::OP_SH;
            6'h2a: op = mips_pkg::OP_SWL;
            6'h2b: op = mips_pkg::OP_SW;
            6'h2e: op = mips_pkg::OP_SWR;
            6'h2f: op = mips_pkg::OP_CACHE;
            default: op = mips_pkg::OP_INVALID;   // special lands here too
        endcase
    end

    assign i_dec.op            = op;
    assign i_dec.rs            = rs;
    assign i_dec.rt            = rt;
    assign i_dec.imm           = inst.i.imm;
    assign i_dec.flag_unsigned = flag_u;

endmodule

`default_nettype wire

//--- verilog/id_r.sv
`timescale 1ns/1ps
`default_nettype none

module id_r (
    input  wire mips_pkg::inst_u inst,
    output mips_pkg::r_dec_t     r_dec
);

    logic [5:0]    funct;
    logic          flag_u;
    mips_pkg::op_e op;

    assign funct = inst.r.funct;

    // addu, subu, sltu
    assign flag_u = (funct == 6'h21) || (funct == 6'h23) || (funct == 6'h2b);

    always_comb begin
        op = mips_pkg::OP_INVALID;
        case (funct)
            // shifts by shamt
            6'h00: op = mips_pkg::OP_SLL;
            6'h02: op = mips_pkg::OP_SRL;
            6'h03: op = mips_pkg::OP_SRA;
            6'h08: op = mips_pkg::OP_JR;
            6'h09: op = mips_pkg::OP_JALR;
            6'h0c: op = mips_pkg::OP_SYSCALL;
            6'h0d: op = mips_pkg::OP_BREAK;
            6'h20: op = mips_pkg::OP_ADD;
            6'h21: op = mips_pkg::OP_ADDU;
            6'h22: op = mips_pkg::OP_SUB;
            6'h23: op = mips_pkg::OP_SUBU;
            6'h24: op = mips_pkg::OP_AND;
            6'h25: op = mips_pkg::OP_OR;
            6'h26: op = mips_pkg::OP_XOR;
            6'h27: op = mips_pkg::OP_NOR;
            6'h2a: op = mips_pkg::OP_SLT;
            6'h2b: op = mips_pkg::OP_SLT;   // sltu, flagged unsigned
            default: op = mips_pkg::OP_INVALID;
        endcase
    end

    assign r_dec.op            = op;
    assign r_dec.rs            = inst.r.rs;
    assign r_dec.rt            = inst.r.rt;
    assign r_dec.rd            = inst.r.rd;
    assign r_dec.shamt         = inst.r.shamt;
    assign r_dec.flag_unsigned = flag_u;

endmodule

`default_nettype wire

//--- verilog/id_merge.sv
`timescale 1ns/1ps
`default_nettype none

module id_merge (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire mips_pkg::inst_u   inst,
    input  wire [31:0]             pc,
    input  wire                    fetch_valid,
    input  wire mips_pkg::i_dec_t  i_dec,
    input  wire mips_pkg::r_dec_t  r_dec,
    input  wire                    hold,
    output logic                   advance,
    output mips_pkg::dec_t         dec,
    output logic                   dec_valid
);

    logic           is_r;
    logic           flag_u;
    logic [15:0]    imm16;
    logic [31:0]    imm32;
    logic [4:0]     dest;
    logic           uses_imm;
    mips_pkg::op_e  op;
    mips_pkg::dec_t dec_d;

    assign is_r   = inst.r.opcode == 6'h00;   // special
    assign op     = is_r ? r_dec.op : i_dec.op;
    assign flag_u = is_r ? r_dec.flag_unsigned : i_dec.flag_unsigned;
    assign imm16  = i_dec.imm;

    always_comb begin
        if (op == mips_pkg::OP_LU)
            imm32 = {imm16, 16'h0000};
        else if (flag_u || op == mips_pkg::OP_AND || op == mips_pkg::OP_OR ||
                 op == mips_pkg::OP_XOR)
            imm32 = {16'h0000, imm16};
        else
            imm32 = {{16{imm16[15]}}, imm16};
    end

    always_comb begin
        dest     = 5'd0;
        uses_imm = 1'b0;
        if (is_r) begin
            case (op)
                mips_pkg::OP_ADD, mips_pkg::OP_ADDU, mips_pkg::OP_SUB,
                mips_pkg::OP_SUBU, mips_pkg::OP_AND, mips_pkg::OP_OR,
                mips_pkg::OP_XOR, mips_pkg::OP_NOR, mips_pkg::OP_SLT,
                mips_pkg::OP_SLL, mips_pkg::OP_SRL, mips_pkg::OP_SRA,
                mips_pkg::OP_JALR:
                    dest = r_dec.rd;
                default:
                    dest = 5'd0;    // jr, syscall, break, invalid
            endcase
        end else begin
            case (op)
                mips_pkg::OP_ADD, mips_pkg::OP_SLT, mips_pkg::OP_AND,
                mips_pkg::OP_OR, mips_pkg::OP_XOR, mips_pkg::OP_LU,
                mips_pkg::OP_LB, mips_pkg::OP_LH, mips_pkg::OP_LW,
                mips_pkg::OP_LWL, mips_pkg::OP_LWR: begin
                    dest     = i_dec.rt;
                    uses_imm = 1'b1;
                end
                mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW,
                mips_pkg::OP_SWL, mips_pkg::OP_SWR, mips_pkg::OP_CACHE:
                    uses_imm = 1'b1;
                mips_pkg::OP_MFC0:
                    dest = i_dec.rt;
                mips_pkg::OP_JAL, mips_pkg::OP_BLTZAL, mips_pkg::OP_BGEZAL:
                    dest = mips_pkg::LINK_REG;
                default:
                    dest = 5'd0;
            endcase
        end
    end

    assign dec_d.op            = op;
    assign dec_d.src_a         = i_dec.rs;    // same bits in both formats
    assign dec_d.src_b         = i_dec.rt;
    assign dec_d.dest          = dest;
    assign dec_d.imm32         = imm32;
    assign dec_d.uses_imm      = uses_imm;
    assign dec_d.flag_unsigned = flag_u;
    assign dec_d.pc            = pc;

    // output register free or not held
    assign advance = fetch_valid && (!dec_valid || !hold);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            dec_valid <= 1'b0;
        else if (advance)
            dec_valid <= 1'b1;
        else if (!hold)
            dec_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (advance)
            dec <= dec_d;
    end

endmodule

`default_nettype wire

//--- verilog/mips_decode.sv
`timescale 1ns/1ps
`default_nettype none

module mips_decode (
    input  wire             clk,
    input  wire             arst_n,
    output logic [31:0]     wb_adr,
    output logic            wb_cyc,
    output logic            wb_stb,
    input  wire  [31:0]     wb_dat,
    input  wire             wb_ack,
    input  wire             hold,
    output mips_pkg::dec_t  dec,
    output logic            dec_valid
);

    mips_pkg::inst_u  inst;
    logic [31:0]      pc;
    logic             fetch_valid;
    logic             advance;
    mips_pkg::i_dec_t i_dec;
    mips_pkg::r_dec_t r_dec;

    if_wb u_if_wb (
        .clk         (clk),
        .arst_n      (arst_n),
        .wb_adr      (wb_adr),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_dat      (wb_dat),
        .wb_ack      (wb_ack),
        .advance     (advance),
        .inst        (inst),
        .pc          (pc),
        .fetch_valid (fetch_valid)
    );

    // both decoders see the same word
    id_i u_id_i (
        .inst  (inst),
        .i_dec (i_dec)
    );

    id_r u_id_r (
        .inst  (inst),
        .r_dec (r_dec)
    );

    id_merge u_id_merge (
        .clk         (clk),
        .arst_n      (arst_n),
        .inst        (inst),
        .pc          (pc),
        .fetch_valid (fetch_valid),
        .i_dec       (i_dec),
        .r_dec       (r_dec),
        .hold        (hold),
        .advance     (advance),
        .dec         (dec),
        .dec_valid   (dec_valid)
    );

endmodule

`default_nettype wire

//--- tb/mips_decode_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mips_decode_properties (
    input wire                 clk,
    input wire                 arst_n,
    input wire [31:0]          wb_adr,
    input wire                 wb_cyc,
    input wire                 wb_stb,
    input wire                 wb_ack,
    input wire                 fetch_valid,
    input wire                 hold,
    input wire mips_pkg::dec_t dec,
    input wire                 dec_valid
);

    int fail_count = 0;     // summed into the closing verdict

    // full fetch register behind a held output blocks new reads
    no_read_when_full: assert property (@(posedge clk) disable iff (!arst_n)
        !wb_cyc && fetch_valid && dec_valid && hold |=> !wb_cyc)
    else begin
        $error("bus cycle started with the fetch register full and held");
        fail_count++;
    end

    // request stays put until the slave acks
    req_held: assert property (@(posedge clk) disable iff (!arst_n)
        wb_cyc && !wb_ack |=> wb_cyc && wb_stb && $stable(wb_adr))
    else begin
        $error("bus request dropped or address moved before ack");
        fail_count++;
    end

    out_held: assert property (@(posedge clk) disable iff (!arst_n)
        dec_valid && hold |=> dec_valid && $stable(dec))
    else begin
        $error("decoded record changed while held");
        fail_count++;
    end

    quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !dec_valid)
    else begin
        $error("dec_valid high during reset");
        fail_count++;
    end

endmodule

bind mips_decode mips_decode_properties u_props (
    .clk         (clk),
    .arst_n      (arst_n),
    .wb_adr      (wb_adr),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_ack      (wb_ack),
    .fetch_valid (fetch_valid),
    .hold        (hold),
    .dec         (dec),
    .dec_valid   (dec_valid)
);

`default_nettype wire

//--- tb/tb_mips_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_decode;

    typedef struct packed {
        logic [31:0]   word;
        mips_pkg::op_e op;
        logic [4:0]    dest;
        logic [31:0]   imm32;
        logic          uses_imm;
        logic          flag_unsigned;
    } vec_t;

    logic           clk;
    logic           arst_n = 1'b0;
    logic [31:0]    wb_adr;
    logic           wb_cyc;
    logic           wb_stb;
    logic [31:0]    wb_dat = 32'h0;
    logic           wb_ack = 1'b0;
    logic           hold = 1'b0;
    mips_pkg::dec_t dec;
    logic           dec_valid;

    vec_t        vectors[$];
    int unsigned wait_left = 0;     // wait states before the next ack
    int          errors = 0;
    int          checks = 0;

    mips_decode dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb_adr    (wb_adr),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_dat    (wb_dat),
        .wb_ack    (wb_ack),
        .hold      (hold),
        .dec       (dec),
        .dec_valid (dec_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] i_word(input int opc, input int rs, input int rt,
                                           input int imm);
        return {6'(opc), 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] r_word(input int rs, input int rt, input int rd,
                                           input int shamt, input int funct);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), 6'(funct)};
    endfunction

    task automatic add_vec(input logic [31:0] word, input mips_pkg::op_e op,
                           input int dest, input logic [31:0] imm32, input int uses_imm,
                           input int flag_unsigned);
        vectors.push_back(vec_t'{word, op, 5'(dest), imm32, uses_imm != 0,
                                 flag_unsigned != 0});
    endtask

    // expected values worked out by hand from the decode rules
    task automatic build_vectors();
        add_vec(i_word('h08, 1, 2, 'hfff0), mips_pkg::OP_ADD, 2, 'hffff_fff0, 1, 0);
        add_vec(i_word('h09, 4, 3, 'h8001), mips_pkg::OP_ADD, 3, 'h0000_8001, 1, 1);
        add_vec(i_word('h0b, 8, 7, 'h9000), mips_pkg::OP_SLT, 7, 'h0000_9000, 1, 1);
        add_vec(i_word('h0c, 10, 9, 'hff00), mips_pkg::OP_AND, 9, 'h0000_ff00, 1, 0);
        add_vec(i_word('h0d, 12, 11, 'h8421), mips_pkg::OP_OR, 11, 'h0000_8421, 1, 0);
        add_vec(i_word('h0e, 14, 13, 'ha5a5), mips_pkg::OP_XOR, 13, 'h0000_a5a5, 1, 0);
        add_vec(i_word('h0f, 0, 15, 'h1234), mips_pkg::OP_LU, 15, 'h1234_0000, 1, 0);
        add_vec(i_word('h20, 17, 16, 'hfffc), mips_pkg::OP_LB, 16, 'hffff_fffc, 1, 0);
        add_vec(i_word('h25, 21, 20, 'hfffe), mips_pkg::OP_LH, 20, 'h0000_fffe, 1, 1);
        add_vec(i_word('h23, 23, 22, 'h0040), mips_pkg::OP_LW, 22, 'h0000_0040, 1, 0);
        add_vec(i_word('h28, 2, 1, 'h8000), mips_pkg::OP_SB, 0, 'hffff_8000, 1, 0);
        add_vec(i_word('h2e, 6, 5, 'hfff1), mips_pkg::OP_SWR, 0, 'hffff_fff1, 1, 0);
        add_vec(i_word('h2f, 7, 1, 'h0020), mips_pkg::OP_CACHE, 0, 'h0000_0020, 1, 0);
        add_vec(i_word('h04, 1, 2, 'hfffe), mips_pkg::OP_BEQ, 0, 'hffff_fffe, 0, 0);
        add_vec(i_word('h01, 5, 'h00, 'h8000), mips_pkg::OP_BLTZ, 0, 'hffff_8000, 0, 0);
        add_vec(i_word('h01, 6, 'h11, 'h0004), mips_pkg::OP_BGEZAL, 31, 'h0000_0004, 0, 0);
        add_vec(i_word('h01, 1, 'h05, 'h0100), mips_pkg::OP_INVALID, 0, 'h0000_0100, 0, 0);
        add_vec(i_word('h03, 0, 0, 'h0100), mips_pkg::OP_JAL, 31, 'h0000_0100, 0, 0);
        add_vec(i_word('h10, 'h00, 8, 'h6000), mips_pkg::OP_MFC0, 8, 'h0000_6000, 0, 0);
        add_vec(i_word('h10, 'h10, 0, 'h0018), mips_pkg::OP_ERET, 0, 'h0000_0018, 0, 0);
        add_vec(i_word('h10, 'h10, 0, 'h0020), mips_pkg::OP_WAIT, 0, 'h0000_0020, 0, 0);
        add_vec(i_word('h10, 'h10, 0, 'h0002), mips_pkg::OP_TLBWI, 0, 'h0000_0002, 0, 0);
        add_vec(i_word('h10, 'h10, 0, 'h003f), mips_pkg::OP_INVALID, 0, 'h0000_003f, 0, 0);
        add_vec(i_word('h3f, 1, 2, 'h1234), mips_pkg::OP_INVALID, 0, 'h0000_1234, 0, 0);
        // special, imm field is rd/shamt/funct
        add_vec(r_word(1, 2, 20, 0, 'h21), mips_pkg::OP_ADDU, 20, 'h0000_a021, 0, 1);
        add_vec(r_word(3, 4, 17, 0, 'h22), mips_pkg::OP_SUB, 17, 'hffff_8822, 0, 0);
        add_vec(r_word(5, 6, 30, 0, 'h24), mips_pkg::OP_AND, 30, 'h0000_f024, 0, 0);
        add_vec(r_word(7, 8, 31, 0, 'h27), mips_pkg::OP_NOR, 31, 'hffff_f827, 0, 0);
        add_vec(r_word(9, 10, 24, 0, 'h2b), mips_pkg::OP_SLT, 24, 'h0000_c02b, 0, 1);
        add_vec(r_word(0, 2, 4, 5, 'h00), mips_pkg::OP_SLL, 4, 'h0000_2140, 0, 0);
        add_vec(r_word(0, 11, 18, 31, 'h02), mips_pkg::OP_SRL, 18, 'hffff_97c2, 0, 0);
        add_vec(r_word(31, 0, 0, 0, 'h08), mips_pkg::OP_JR, 0, 'h0000_0008, 0, 0);
        add_vec(r_word(4, 0, 25, 0, 'h09), mips_pkg::OP_JALR, 25, 'hffff_c809, 0, 0);
        add_vec(r_word(0, 0, 0, 0, 'h0c), mips_pkg::OP_SYSCALL, 0, 'h0000_000c, 0, 0);
        add_vec(r_word(1, 2, 3, 0, 'h01), mips_pkg::OP_INVALID, 0, 'h0000_1801, 0, 0);
    endtask

    function automatic logic [31:0] mem_word(input logic [31:0] adr);
        logic [31:0] off;
        off = adr - mips_pkg::RESET_PC;
        if (off[1:0] == 2'b00 && (off >> 2) < 32'(vectors.size()))
            return vectors[off[31:2]].word;
        return ~adr;    // filler past the table
    endfunction

    // instruction memory and random hold, one process for all draws
    always @(posedge clk) begin
        if (!arst_n) begin
            wb_ack    <= 1'b0;
            hold      <= 1'b0;
            wait_left <= $urandom_range(3, 0);
        end else begin
            hold <= ($urandom_range(3, 0) == 0);
            if (wb_ack)
                wb_ack <= 1'b0;     // single beat
            else if (wb_cyc && wb_stb) begin
                if (wait_left == 0) begin
                    wb_ack    <= 1'b1;
                    wb_dat    <= mem_word(wb_adr);
                    wait_left <= $urandom_range(3, 0);
                end else
                    wait_left <= wait_left - 1;
            end
        end
    end

    task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("FAILED at time %0t: %s expected %h, got %h", $time, name, exp, act);
    endtask

    // stable half of the cycle, beat taken at the next rising edge
    task automatic wait_beat();
        @(negedge clk);
        while (!(dec_valid && !hold))
            @(negedge clk);
    endtask

    task automatic check_entry(input int k);
        vec_t        v;
        logic [31:0] exp_pc;
        int          errs_before;
        v           = vectors[k];
        exp_pc      = mips_pkg::RESET_PC + 32'(k) * mips_pkg::PC_STEP;
        errs_before = errors;
        checks      += 8;
        if (dec.op !== v.op)
            mismatch("dec.op", 32'(v.op), 32'(dec.op));
        if (dec.src_a !== v.word[25:21])
            mismatch("dec.src_a", 32'(v.word[25:21]), 32'(dec.src_a));
        if (dec.src_b !== v.word[20:16])
            mismatch("dec.src_b", 32'(v.word[20:16]), 32'(dec.src_b));
        if (dec.dest !== v.dest)
            mismatch("dec.dest", 32'(v.dest), 32'(dec.dest));
        if (dec.imm32 !== v.imm32)
            mismatch("dec.imm32", v.imm32, dec.imm32);
        if (dec.uses_imm !== v.uses_imm)
            mismatch("dec.uses_imm", 32'(v.uses_imm), 32'(dec.uses_imm));
        if (dec.flag_unsigned !== v.flag_unsigned)
            mismatch("dec.flag_unsigned", 32'(v.flag_unsigned), 32'(dec.flag_unsigned));
        if (dec.pc !== exp_pc)
            mismatch("dec.pc", exp_pc, dec.pc);
        $display("entry %0d pc %h word %h %s: %s", k, exp_pc, v.word, v.op.name(),
                 (errors == errs_before) ? "pass" : "fail");
    endtask

    initial begin
        void'($urandom(32'hb8ca_1266));
        build_vectors();
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        for (int k = 0; k < vectors.size(); k++) begin
            wait_beat();
            check_entry(k);
        end
        $display("%0d entries, %0d checks, %0d errors, %0d assertion failures",
                 vectors.size(), checks, errors, dut.u_props.fail_count);
        if (errors == 0 && dut.u_props.fail_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    initial begin : watchdog
        int limit;
        #1;
        limit = vectors.size() * 12 + 20;
        repeat (limit) @(posedge clk);
        $display("timeout: decoded output stalled, run stopped after %0d cycles", limit);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- mips_decode.f
verilog/mips_pkg.sv
verilog/if_wb.sv
verilog/id_i.sv
verilog/id_r.sv
verilog/id_merge.sv
verilog/mips_decode.sv
tb/mips_decode_properties.sv
tb/tb_mips_decode.sv

//--- Makefile
TOP := tb_mips_decode

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f mips_decode.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf obj_dir
